// ==== hw/uart_apb.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_apb
    import uart_reg_pkg::*;
    import uart_line_pkg::*;
#(
    parameter int FIFO_DEPTH  = 16,
    parameter int OSR         = 16,
    parameter int SYNC_STAGES = 2
) (
    input  wire logic                  PCLK,
    input  wire logic                  PRESETn,
    input  wire logic                  PSEL,
    input  wire logic                  PENABLE,
    input  wire logic                  PWRITE,
    input  wire logic [APB_ADDR_W-1:0] PADDR,
    input  wire apb_word_t             PWDATA,
    output apb_word_t                  PRDATA,
    output logic                       PREADY,
    input  wire logic                  RXD,
    output logic                       TXD,
    output logic                       IRQ
);

    logic       tx_full, tx_empty, tx_push, tx_pop, tx_clear;
    logic       rx_full, rx_empty, rx_push, rx_pop, rx_clear;
    uart_char_t tx_push_data, tx_head, rx_push_data, rx_head, rx_char;
    logic       uart_en, tx_en, rx_en, parity_en, parity_odd, loopback;
    baud_div_t  baud_div;
    logic       osr_tick, rx_line;
    logic       rx_char_valid, frame_err, parity_err, rx_busy, tx_busy, tx_done;

    assign rx_line = loopback ? TXD : RXD; // internal loopback of the transmitter.

    uart_apb_regs #(.FIFO_DEPTH(FIFO_DEPTH)) u_regs (
        .PCLK, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .PRDATA, .PREADY,
        .tx_full, .tx_empty, .rx_full, .rx_empty, .rx_head,
        .rx_char_valid, .rx_char, .frame_err, .parity_err, .rx_busy,
        .tx_busy, .tx_done,
        .tx_push, .tx_push_data, .tx_clear, .rx_push, .rx_push_data, .rx_pop, .rx_clear,
        .uart_en, .tx_en, .rx_en, .parity_en, .parity_odd, .loopback, .baud_div, .IRQ
    );

    uart_fifo #(.DEPTH(FIFO_DEPTH)) u_tx_fifo (
        .PCLK, .PRESETn,
        .clear     (tx_clear),
        .push      (tx_push),
        .push_data (tx_push_data),
        .pop       (tx_pop),
        .head      (tx_head),
        .full      (tx_full),
        .empty     (tx_empty),
        .level     ()
    );

    uart_fifo #(.DEPTH(FIFO_DEPTH)) u_rx_fifo (
        .PCLK, .PRESETn,
        .clear     (rx_clear),
        .push      (rx_push),
        .push_data (rx_push_data),
        .pop       (rx_pop),
        .head      (rx_head),
        .full      (rx_full),
        .empty     (rx_empty),
        .level     ()
    );

    uart_baud_gen u_baud_gen (.PCLK, .PRESETn, .uart_en, .baud_div, .osr_tick);

    uart_tx #(.OSR(OSR)) u_tx (
        .PCLK, .PRESETn, .uart_en, .tx_en, .parity_en, .parity_odd, .osr_tick,
        .tx_empty, .tx_head, .tx_pop, .TXD, .tx_busy, .tx_done
    );

    uart_rx #(.OSR(OSR), .SYNC_STAGES(SYNC_STAGES)) u_rx (
        .PCLK, .PRESETn, .uart_en, .rx_en, .parity_en, .parity_odd, .osr_tick,
        .rx_line, .rx_char, .rx_char_valid, .frame_err, .parity_err, .rx_busy
    );

endmodule

`default_nettype wire

// ==== hw/uart_apb_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_apb_regs
    import uart_reg_pkg::*;
    import uart_line_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic                  PCLK,
    input  wire logic                  PRESETn,
    input  wire logic                  PSEL,
    input  wire logic                  PENABLE,
    input  wire logic                  PWRITE,
    input  wire logic [APB_ADDR_W-1:0] PADDR,
    input  wire apb_word_t             PWDATA,
    output apb_word_t                  PRDATA,
    output logic                       PREADY,
    input  wire logic                  tx_full,
    input  wire logic                  tx_empty,
    input  wire logic                  rx_full,
    input  wire logic                  rx_empty,
    input  wire uart_char_t            rx_head,
    input  wire logic                  rx_char_valid,
    input  wire uart_char_t            rx_char,
    input  wire logic                  frame_err,
    input  wire logic                  parity_err,
    input  wire logic                  rx_busy,
    input  wire logic                  tx_busy,
    input  wire logic                  tx_done,
    output logic                       tx_push,
    output uart_char_t                 tx_push_data,
    output logic                       tx_clear,
    output logic                       rx_push,
    output uart_char_t                 rx_push_data,
    output logic                       rx_pop,
    output logic                       rx_clear,
    output logic                       uart_en,
    output logic                       tx_en,
    output logic                       rx_en,
    output logic                       parity_en,
    output logic                       parity_odd,
    output logic                       loopback,
    output baud_div_t                  baud_div,
    output logic                       IRQ
);

    // the upper half of BAUD reports the FIFO depth, read only.
    localparam logic [15:0] DEPTH_FIELD = 16'(FIFO_DEPTH);

    logic             wr_en;
    logic             rd_en;
    logic             tx_write;
    logic [7:0]       ctrl_q;
    baud_div_t        baud_q;
    logic [INT_W-1:0] int_en_q;
    logic [INT_W-1:0] int_st_q;
    logic [INT_W-1:0] int_set;
    logic [INT_W-1:0] int_clr;
    logic             tx_werr_q;
    apb_word_t        status_word;
    apb_word_t        rd_data;

    assign wr_en    = PSEL && PENABLE && PWRITE;
    assign rd_en    = PSEL && PENABLE && !PWRITE;
    assign tx_write = wr_en && (PADDR == ADDR_DATA);
    assign PREADY   = 1'b1;

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            ctrl_q   <= CTRL_RESET;
            baud_q   <= '0;
            int_en_q <= '0;
        end else if (wr_en) begin
            case (PADDR)
                ADDR_CTRL:       ctrl_q   <= PWDATA[7:0] & CTRL_MASK;
                ADDR_BAUD:       baud_q   <= PWDATA[15:0];
                ADDR_INT_ENABLE: int_en_q <= PWDATA[INT_W-1:0];
                default: ;
            endcase
        end
    end

    assign uart_en    = ctrl_q[CTRL_UART_EN];
    assign rx_en      = ctrl_q[CTRL_RX_EN];
    assign tx_en      = ctrl_q[CTRL_TX_EN];
    assign loopback   = ctrl_q[CTRL_LOOPBACK];
    assign parity_en  = ctrl_q[CTRL_PARITY_EN];
    assign parity_odd = ctrl_q[CTRL_PARITY_ODD];
    assign baud_div   = baud_q;

    assign tx_push      = tx_write && !tx_full; // a write to a full FIFO is dropped.
    assign tx_push_data = PWDATA[7:0];
    assign tx_clear     = wr_en && (PADDR == ADDR_FIFO_CTRL) && PWDATA[FC_TX_CLEAR];
    assign rx_clear     = wr_en && (PADDR == ADDR_FIFO_CTRL) && PWDATA[FC_RX_CLEAR];
    assign rx_push      = rx_char_valid && !rx_full;
    assign rx_push_data = rx_char;
    assign rx_pop       = rd_en && (PADDR == ADDR_DATA) && !rx_empty;

    always_comb begin
        int_set              = '0;
        int_set[INT_RX_DONE] = rx_push;
        int_set[INT_TX_DONE] = tx_done;
        int_set[INT_FRAME]   = frame_err;
        int_set[INT_PARITY]  = parity_err;
        int_set[INT_OVERRUN] = rx_char_valid && rx_full;
    end

    assign int_clr = (wr_en && (PADDR == ADDR_INT_STATUS)) ? PWDATA[INT_W-1:0] : '0;

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            int_st_q  <= '0;
            tx_werr_q <= 1'b0;
        end else begin
            int_st_q <= (int_st_q & ~int_clr) | int_set; // a new event beats the clear.
            if (tx_write && tx_full) begin
                tx_werr_q <= 1'b1;
            end else if (tx_clear || !uart_en) begin
                tx_werr_q <= 1'b0;
            end
        end
    end

    assign IRQ = |(int_st_q & int_en_q);

    always_comb begin
        status_word             = '0;
        status_word[ST_RX_AVAIL] = !rx_empty;
        status_word[ST_TX_EMPTY] = tx_empty;
        status_word[ST_RX_FULL]  = rx_full;
        status_word[ST_TX_FULL]  = tx_full;
        status_word[ST_RX_BUSY]  = rx_busy;
        status_word[ST_TX_BUSY]  = tx_busy;
        status_word[ST_IDLE]     = !rx_busy && !tx_busy && tx_empty;
        status_word[ST_TX_WERR]  = tx_werr_q;
    end

    always_comb begin
        case (PADDR)
            ADDR_DATA:       rd_data = rx_empty ? '0 : {24'd0, rx_head};
            ADDR_STATUS:     rd_data = status_word;
            ADDR_CTRL:       rd_data = {24'd0, ctrl_q};
            ADDR_BAUD:       rd_data = {DEPTH_FIELD, baud_q};
            ADDR_INT_STATUS: rd_data = {{(32-INT_W){1'b0}}, int_st_q};
            ADDR_INT_ENABLE: rd_data = {{(32-INT_W){1'b0}}, int_en_q};
            default:         rd_data = '0;
        endcase
    end

    assign PRDATA = rd_en ? rd_data : '0;

endmodule

`default_nettype wire

// ==== hw/uart_baud_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_baud_gen
    import uart_line_pkg::*;
(
    input  wire logic      PCLK,
    input  wire logic      PRESETn,
    input  wire logic      uart_en,
    input  wire baud_div_t baud_div,
    output logic           osr_tick
);

    baud_div_t cnt_q;

    // one tick every baud_div+1 cycles.
    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            cnt_q    <= '0;
            osr_tick <= 1'b0;
        end else if (!uart_en) begin
            cnt_q    <= baud_div;
            osr_tick <= 1'b0;
        end else if (cnt_q == '0) begin
            cnt_q    <= baud_div;
            osr_tick <= 1'b1;
        end else begin
            cnt_q    <= cnt_q - 1'b1;
            osr_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/uart_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_fifo #(
    parameter  int DEPTH = 16,
    localparam int LVL_W = $clog2(DEPTH + 1)
) (
    input  wire logic             PCLK,
    input  wire logic             PRESETn,
    input  wire logic             clear,
    input  wire logic             push,
    input  wire logic [7:0]       push_data,
    input  wire logic             pop,
    output logic [7:0]            head,
    output logic                  full,
    output logic                  empty,
    output logic [LVL_W-1:0]      level
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [7:0]       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [LVL_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge PCLK) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data;
        end
    end

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (clear) begin
            wr_ptr_q <= '0; // clear wins over a push or pop in the same cycle.
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) wr_ptr_q <= ptr_next(wr_ptr_q);
            if (do_pop)  rd_ptr_q <= ptr_next(rd_ptr_q);
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    assign head  = mem[rd_ptr_q]; // valid whenever the FIFO holds data.
    assign full  = (count_q == LVL_W'(DEPTH));
    assign empty = (count_q == '0);
    assign level = count_q;

endmodule

`default_nettype wire

// ==== hw/uart_line_pkg.sv ====
`default_nettype none

package uart_line_pkg;

    typedef logic [7:0]  uart_char_t;
    typedef logic [15:0] baud_div_t;
    typedef logic [31:0] apb_word_t;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_t;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_t;

endpackage

`default_nettype wire

// ==== hw/uart_reg_pkg.sv ====
`default_nettype none

package uart_reg_pkg;

    localparam int APB_ADDR_W = 6;

    localparam logic [APB_ADDR_W-1:0] ADDR_DATA       = 6'h00;
    localparam logic [APB_ADDR_W-1:0] ADDR_STATUS     = 6'h04;
    localparam logic [APB_ADDR_W-1:0] ADDR_CTRL       = 6'h08;
    localparam logic [APB_ADDR_W-1:0] ADDR_BAUD       = 6'h0C;
    localparam logic [APB_ADDR_W-1:0] ADDR_FIFO_CTRL  = 6'h10;
    localparam logic [APB_ADDR_W-1:0] ADDR_INT_STATUS = 6'h14;
    localparam logic [APB_ADDR_W-1:0] ADDR_INT_ENABLE = 6'h18;

    localparam int CTRL_UART_EN    = 0;
    localparam int CTRL_RX_EN      = 1;
    localparam int CTRL_TX_EN      = 2;
    localparam int CTRL_LOOPBACK   = 3;
    localparam int CTRL_PARITY_EN  = 6;
    localparam int CTRL_PARITY_ODD = 7;

    localparam logic [7:0] CTRL_RESET = 8'h07; // uart, rx and tx enabled.
    localparam logic [7:0] CTRL_MASK  = 8'hCF;

    localparam int ST_RX_AVAIL = 0;
    localparam int ST_TX_EMPTY = 1;
    localparam int ST_RX_FULL  = 2;
    localparam int ST_TX_FULL  = 3;
    localparam int ST_RX_BUSY  = 4;
    localparam int ST_TX_BUSY  = 5;
    localparam int ST_IDLE     = 7;
    localparam int ST_TX_WERR  = 11;

    localparam int INT_RX_DONE = 0;
    localparam int INT_TX_DONE = 1;
    localparam int INT_FRAME   = 2;
    localparam int INT_PARITY  = 3;
    localparam int INT_OVERRUN = 4;
    localparam int INT_W       = 5;

    localparam int FC_RX_CLEAR = 0;
    localparam int FC_TX_CLEAR = 1;

endpackage

`default_nettype wire

// ==== hw/uart_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_rx
    import uart_line_pkg::*;
#(
    parameter int OSR         = 16,
    parameter int SYNC_STAGES = 2
) (
    input  wire logic PCLK,
    input  wire logic PRESETn,
    input  wire logic uart_en,
    input  wire logic rx_en,
    input  wire logic parity_en,
    input  wire logic parity_odd,
    input  wire logic osr_tick,
    input  wire logic rx_line,
    output uart_char_t rx_char,
    output logic       rx_char_valid,
    output logic       frame_err,
    output logic       parity_err,
    output logic       rx_busy
);

    localparam int CNT_W = $clog2(2 * OSR);
    localparam int HALF  = OSR / 2;

    logic [SYNC_STAGES-1:0] sync_q;
    logic                   line;
    rx_state_t              state_q;
    logic [CNT_W-1:0]       cnt_q;
    logic [2:0]             bit_idx_q;
    uart_char_t             shift_q;
    logic                   par_bad_q;
    logic                   stop_ok_q;
    logic                   mid_bit;

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            sync_q <= '1; // an idle line is high.
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], rx_line};
        end
    end

    assign line    = sync_q[SYNC_STAGES-1];
    assign mid_bit = osr_tick && (cnt_q == CNT_W'(OSR - 1));

    always_ff @(posedge PCLK) begin
        if (uart_en && rx_en && (state_q == RX_DATA) && mid_bit) begin
            shift_q <= {line, shift_q[7:1]}; // lsb arrives first.
        end
    end

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            state_q       <= RX_IDLE;
            cnt_q         <= '0;
            bit_idx_q     <= '0;
            par_bad_q     <= 1'b0;
            stop_ok_q     <= 1'b0;
            rx_char_valid <= 1'b0;
            frame_err     <= 1'b0;
            parity_err    <= 1'b0;
        end else begin
            rx_char_valid <= 1'b0;
            frame_err     <= 1'b0;
            parity_err    <= 1'b0;
            if (!uart_en || !rx_en) begin
                state_q <= RX_IDLE;
                cnt_q   <= '0;
            end else begin
                case (state_q)
                    RX_IDLE: begin
                        cnt_q <= '0;
                        if (!line) state_q <= RX_START;
                    end
                    RX_START: begin
                        if (osr_tick && (cnt_q == CNT_W'(HALF - 1))) begin
                            cnt_q     <= '0;
                            bit_idx_q <= '0;
                            par_bad_q <= 1'b0;
                            state_q   <= line ? RX_IDLE : RX_DATA; // high here is a glitch.
                        end else if (osr_tick) begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                    RX_DATA: begin
                        if (mid_bit) begin
                            cnt_q <= '0;
                            if (bit_idx_q == 3'd7) begin
                                state_q <= parity_en ? RX_PARITY : RX_STOP;
                            end else begin
                                bit_idx_q <= bit_idx_q + 1'b1;
                            end
                        end else if (osr_tick) begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                    RX_PARITY: begin
                        if (mid_bit) begin
                            cnt_q     <= '0;
                            par_bad_q <= line != (^shift_q ^ parity_odd);
                            state_q   <= RX_STOP;
                        end else if (osr_tick) begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                    RX_STOP: begin
                        // sample mid stop bit, deliver half a bit later.
                        if (mid_bit) stop_ok_q <= line;
                        if (osr_tick && (cnt_q == CNT_W'(OSR + HALF - 1))) begin
                            cnt_q         <= '0;
                            state_q       <= RX_IDLE;
                            rx_char_valid <= stop_ok_q;
                            parity_err    <= stop_ok_q && par_bad_q;
                            frame_err     <= !stop_ok_q;
                        end else if (osr_tick) begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                    default: state_q <= RX_IDLE;
                endcase
            end
        end
    end

    assign rx_char = shift_q;
    assign rx_busy = (state_q != RX_IDLE);

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tx
    import uart_line_pkg::*;
#(
    parameter int OSR = 16
) (
    input  wire logic       PCLK,
    input  wire logic       PRESETn,
    input  wire logic       uart_en,
    input  wire logic       tx_en,
    input  wire logic       parity_en,
    input  wire logic       parity_odd,
    input  wire logic       osr_tick,
    input  wire logic       tx_empty,
    input  wire uart_char_t tx_head,
    output logic            tx_pop,
    output logic            TXD,
    output logic            tx_busy,
    output logic            tx_done
);

    localparam int CNT_W = (OSR > 1) ? $clog2(OSR) : 1;

    tx_state_t  state_q;
    logic [CNT_W-1:0] tick_cnt_q;
    logic [2:0] bit_idx_q;
    uart_char_t data_q;
    logic       par_q;
    logic       bit_end;

    assign bit_end = osr_tick && (tick_cnt_q == CNT_W'(OSR - 1));
    assign tx_pop  = (state_q == TX_IDLE) && uart_en && tx_en && !tx_empty && bit_end;

    // bit period counter runs freely so frames start on a bit boundary.
    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            tick_cnt_q <= '0;
        end else if (!uart_en) begin
            tick_cnt_q <= '0;
        end else if (osr_tick) begin
            tick_cnt_q <= bit_end ? '0 : tick_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge PCLK) begin
        if (tx_pop) begin
            data_q <= tx_head;
            par_q  <= ^tx_head ^ parity_odd; // even parity unless parity_odd.
        end
    end

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            state_q   <= TX_IDLE;
            bit_idx_q <= '0;
            TXD       <= 1'b1;
            tx_done   <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            if (!uart_en) begin
                state_q <= TX_IDLE;
                TXD     <= 1'b1;
            end else if (bit_end) begin
                case (state_q)
                    TX_IDLE: begin
                        if (tx_pop) begin
                            state_q <= TX_START;
                            TXD     <= 1'b0;
                        end
                    end
                    TX_START: begin
                        state_q   <= TX_DATA;
                        bit_idx_q <= '0;
                        TXD       <= data_q[0];
                    end
                    TX_DATA: begin
                        if (bit_idx_q == 3'd7) begin
                            state_q <= parity_en ? TX_PARITY : TX_STOP;
                            TXD     <= parity_en ? par_q : 1'b1;
                        end else begin
                            bit_idx_q <= bit_idx_q + 1'b1;
                            TXD       <= data_q[bit_idx_q + 3'd1];
                        end
                    end
                    TX_PARITY: begin
                        state_q <= TX_STOP;
                        TXD     <= 1'b1;
                    end
                    TX_STOP: begin
                        state_q <= TX_IDLE;
                        tx_done <= 1'b1;
                    end
                    default: state_q <= TX_IDLE;
                endcase
            end
        end
    end

    assign tx_busy = (state_q != TX_IDLE);

endmodule

`default_nettype wire

// ==== list.f ====
hw/uart_reg_pkg.sv
hw/uart_line_pkg.sv
hw/uart_fifo.sv
hw/uart_baud_gen.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_apb_regs.sv
hw/uart_apb.sv
verif/uart_apb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the result from the simulation log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps --top-module uart_apb_tb \
    -f list.f -o uart_apb_tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/uart_apb_tb_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log && { echo "simulation reported errors"; exit 1; } || exit 0

// ==== verif/uart_apb_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_apb_tb
    import uart_reg_pkg::*;
();

    localparam int CLK_PERIOD  = 100;
    localparam int FIFO_DEPTH  = 16;
    localparam int OSR         = 16;
    localparam int BAUD_DIV    = 1;
    localparam int BIT_NS      = OSR * (BAUD_DIV + 1) * CLK_PERIOD;
    localparam int TX_BYTES    = 20;
    localparam int LOOP_BYTES  = 12;
    localparam int FRAME_COUNT = TX_BYTES + LOOP_BYTES + 2 + FIFO_DEPTH + 1;
    localparam int WATCHDOG_NS = FRAME_COUNT * 11 * OSR * (BAUD_DIV + 1) * CLK_PERIOD * 2;

    logic                  PCLK;
    logic                  PRESETn;
    logic                  PSEL;
    logic                  PENABLE;
    logic                  PWRITE;
    logic [APB_ADDR_W-1:0] PADDR;
    logic [31:0]           PWDATA;
    logic [31:0]           PRDATA;
    logic                  PREADY;
    logic                  RXD;
    logic                  TXD;
    logic                  IRQ;

    string      test_name;
    int         check_count;
    int         error_count;
    int         test_errors;
    logic [7:0] expected_q[$];

    uart_apb #(.FIFO_DEPTH(FIFO_DEPTH), .OSR(OSR), .SYNC_STAGES(2)) i_uart_apb (
        .PCLK, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .PRDATA, .PREADY,
        .RXD, .TXD, .IRQ
    );

    initial begin
        PCLK = 1'b0;
        forever #(CLK_PERIOD / 2) PCLK = ~PCLK;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: simulation did not finish");
        $display("Checks failed");
        $finish;
    end

    task automatic check_value(input string label, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            test_errors++;
            $display("Fail %s: %s expected 0x%08h, actual 0x%08h",
                     test_name, label, expected, actual);
        end
    endtask

    // picks the bit that makes the count of ones even, or odd when odd is set.
    function automatic logic parity_bit_for(input logic [7:0] data, input logic odd);
        int ones;
        int i;
        ones = 0;
        for (i = 0; i < 8; i++) begin
            ones += int'(data[i]);
        end
        return odd ? (ones % 2 == 0) : (ones % 2 == 1);
    endfunction

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("test %s finished with %0d mismatches", test_name, test_errors);
    endtask

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
        @(negedge PCLK);
        PSEL    = 1'b1; // setup phase.
        PENABLE = 1'b0;
        PWRITE  = 1'b1;
        PADDR   = addr;
        PWDATA  = data;
        @(negedge PCLK);
        PENABLE = 1'b1;
        @(negedge PCLK);
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data);
        @(negedge PCLK);
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
        PADDR   = addr;
        @(negedge PCLK);
        PENABLE = 1'b1;
        #(CLK_PERIOD / 4);
        data = PRDATA; // read data is valid before the edge that ends the access.
        check_value("pready", 32'd1, 32'(PREADY));
        @(negedge PCLK);
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic wait_status(input int bit_pos, input logic value);
        logic [31:0] st;
        apb_read(ADDR_STATUS, st);
        while (st[bit_pos] !== value) begin
            apb_read(ADDR_STATUS, st);
        end
    endtask

    // samples each bit half a clock after its centre, counted from the start edge.
    task automatic capture_tx_frame(input logic par_en, output logic start_bit,
                                    output logic [7:0] data, output logic par_bit,
                                    output logic stop_bit);
        int i;
        @(negedge TXD);
        #(BIT_NS / 2 + CLK_PERIOD / 2);
        start_bit = TXD;
        for (i = 0; i < 8; i++) begin
            #(BIT_NS);
            data[i] = TXD;
        end
        par_bit = 1'b0;
        if (par_en) begin
            #(BIT_NS);
            par_bit = TXD;
        end
        #(BIT_NS);
        stop_bit = TXD;
    endtask

    task automatic drive_rx_frame(input logic [7:0] data, input logic par_en,
                                  input logic par_bit, input logic stop_bit);
        int i;
        @(negedge PCLK);
        RXD = 1'b0;
        #(BIT_NS);
        for (i = 0; i < 8; i++) begin
            RXD = data[i];
            #(BIT_NS);
        end
        if (par_en) begin
            RXD = par_bit;
            #(BIT_NS);
        end
        RXD = stop_bit;
        #(BIT_NS);
        RXD = 1'b1;
        #(BIT_NS); // one idle bit lets the receiver finish the frame.
    endtask

    task automatic verify_reset_values();
        logic [31:0] rd;
        begin_test("reset_values");
        apb_read(ADDR_CTRL, rd);
        check_value("ctrl", 32'h7, rd);
        apb_read(ADDR_STATUS, rd);
        check_value("status", (32'd1 << ST_TX_EMPTY) | (32'd1 << ST_IDLE), rd);
        apb_read(ADDR_INT_STATUS, rd);
        check_value("int_status", 32'd0, rd);
        apb_read(ADDR_INT_ENABLE, rd);
        check_value("int_enable", 32'd0, rd);
        check_value("txd", 32'd1, 32'(TXD));
        check_value("irq", 32'd0, 32'(IRQ));
        end_test();
    endtask

    task automatic send_tx_frames();
        logic [7:0]  b;
        logic [7:0]  got;
        logic [7:0]  exp;
        logic        pe;
        logic        po;
        logic        start_bit;
        logic        par_bit;
        logic        stop_bit;
        logic [31:0] rd;
        int          n;
        begin_test("tx_framing");
        apb_write(ADDR_INT_STATUS, 32'h1F);
        for (n = 0; n < TX_BYTES; n++) begin
            b  = 8'($urandom);
            pe = 1'($urandom);
            po = 1'($urandom);
            apb_write(ADDR_CTRL, 32'h7 | (32'(pe) << CTRL_PARITY_EN)
                                       | (32'(po) << CTRL_PARITY_ODD));
            expected_q.push_back(b);
            apb_write(ADDR_DATA, 32'(b));
            capture_tx_frame(pe, start_bit, got, par_bit, stop_bit);
            exp = expected_q.pop_front();
            check_value("start bit", 32'd0, 32'(start_bit));
            check_value("data", 32'(exp), 32'(got));
            if (pe) begin
                check_value("parity bit", 32'(parity_bit_for(exp, po)), 32'(par_bit));
            end
            check_value("stop bit", 32'd1, 32'(stop_bit));
            wait_status(ST_IDLE, 1'b1);
        end
        apb_read(ADDR_INT_STATUS, rd);
        check_value("int_tx_done", 32'd1, 32'(rd[INT_TX_DONE]));
        end_test();
    endtask

    task automatic echo_loopback();
        logic [7:0]  b;
        logic [31:0] rd;
        int          n;
        begin_test("loopback");
        apb_write(ADDR_INT_STATUS, 32'h1F);
        apb_write(ADDR_CTRL, 32'h0F);
        for (n = 0; n < LOOP_BYTES; n++) begin
            b = 8'($urandom);
            expected_q.push_back(b);
            apb_write(ADDR_DATA, 32'(b));
        end
        for (n = 0; n < LOOP_BYTES; n++) begin
            wait_status(ST_RX_AVAIL, 1'b1);
            apb_read(ADDR_DATA, rd);
            check_value("rx data", 32'(expected_q.pop_front()), rd);
        end
        wait_status(ST_IDLE, 1'b1);
        apb_read(ADDR_INT_STATUS, rd);
        check_value("int_rx_done", 32'd1, 32'(rd[INT_RX_DONE]));
        check_value("irq masked", 32'd0, 32'(IRQ));
        apb_write(ADDR_INT_ENABLE, 32'd1 << INT_RX_DONE);
        check_value("irq enabled", 32'd1, 32'(IRQ));
        apb_write(ADDR_INT_STATUS, 32'h1F);
        apb_read(ADDR_INT_STATUS, rd);
        check_value("int_status cleared", 32'd0, rd);
        check_value("irq cleared", 32'd0, 32'(IRQ));
        apb_write(ADDR_INT_ENABLE, 32'd0);
        end_test();
    endtask

    task automatic inject_rx_errors();
        logic [7:0]  b;
        logic [31:0] rd;
        begin_test("rx_errors");
        apb_write(ADDR_CTRL, 32'h47); // even parity, loopback off.
        apb_write(ADDR_INT_STATUS, 32'h1F);
        b = 8'($urandom);
        drive_rx_frame(b, 1'b1, ~parity_bit_for(b, 1'b0), 1'b1);
        wait_status(ST_RX_AVAIL, 1'b1);
        apb_read(ADDR_DATA, rd);
        check_value("bad parity data", 32'(b), rd);
        apb_read(ADDR_INT_STATUS, rd);
        check_value("int_parity", 32'd1, 32'(rd[INT_PARITY]));
        b = 8'($urandom);
        drive_rx_frame(b, 1'b1, parity_bit_for(b, 1'b0), 1'b0);
        wait_status(ST_RX_BUSY, 1'b0);
        apb_read(ADDR_INT_STATUS, rd);
        check_value("int_frame", 32'd1, 32'(rd[INT_FRAME]));
        apb_read(ADDR_STATUS, rd);
        check_value("no byte delivered", 32'd0, 32'(rd[ST_RX_AVAIL]));
        apb_read(ADDR_DATA, rd);
        check_value("empty read", 32'd0, rd);
        end_test();
    endtask

    task automatic overfill_fifos();
        logic [7:0]  b;
        logic [31:0] rd;
        int          n;
        begin_test("fifo_limits");
        apb_write(ADDR_CTRL, 32'h03);
        apb_write(ADDR_INT_STATUS, 32'h1F);
        for (n = 0; n < FIFO_DEPTH + 1; n++) begin
            apb_write(ADDR_DATA, 32'($urandom) & 32'hFF);
        end
        apb_read(ADDR_STATUS, rd);
        check_value("tx full", 32'd1, 32'(rd[ST_TX_FULL]));
        check_value("tx write error", 32'd1, 32'(rd[ST_TX_WERR]));
        apb_write(ADDR_FIFO_CTRL, 32'd1 << FC_TX_CLEAR);
        apb_read(ADDR_STATUS, rd);
        check_value("tx empty after clear", 32'd1, 32'(rd[ST_TX_EMPTY]));
        check_value("tx write error cleared", 32'd0, 32'(rd[ST_TX_WERR]));
        for (n = 0; n < FIFO_DEPTH + 1; n++) begin
            b = 8'($urandom);
            if (n < FIFO_DEPTH) expected_q.push_back(b); // the last byte overruns.
            drive_rx_frame(b, 1'b0, 1'b0, 1'b1);
        end
        apb_read(ADDR_INT_STATUS, rd);
        check_value("int_overrun", 32'd1, 32'(rd[INT_OVERRUN]));
        apb_read(ADDR_STATUS, rd);
        check_value("rx full", 32'd1, 32'(rd[ST_RX_FULL]));
        for (n = 0; n < FIFO_DEPTH; n++) begin
            apb_read(ADDR_DATA, rd);
            check_value("rx fifo data", 32'(expected_q.pop_front()), rd);
        end
        apb_read(ADDR_DATA, rd); // every slot now holds an old byte.
        check_value("empty read after drain", 32'd0, rd);
        end_test();
    endtask

    initial begin
        PRESETn     = 1'b0;
        PSEL        = 1'b0;
        PENABLE     = 1'b0;
        PWRITE      = 1'b0;
        PADDR       = '0;
        PWDATA      = '0;
        RXD         = 1'b1;
        check_count = 0;
        error_count = 0;
        test_errors = 0;
        void'($urandom(32'hedd3_bb5f));
        repeat (4) @(negedge PCLK);
        PRESETn = 1'b1;

        verify_reset_values();
        apb_write(ADDR_BAUD, 32'(BAUD_DIV));
        send_tx_frames();
        echo_loopback();
        inject_rx_errors();
        overfill_fifos();

        $display("%0d checks run, %0d mismatches", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
